//--- keyExpand.f
+incdir+logic
logic/aesKeyPkg.sv
logic/aesSbox.sv
logic/keyRoundStep.sv
logic/keySequencer.sv
logic/roundKeyStore.sv
logic/keyExpand.sv
testbench/tbClock.sv
testbench/keyExpand_assert.sv
testbench/tbKeyExpand.sv

//--- Makefile
TOOL      = verilator
TOP       = tbKeyExpand
FILELIST  = keyExpand.f
FLAGS     = --binary --timing --assert --top-module $(TOP)
LINTFLAGS = --lint-only --timing --top-module $(TOP)
BUILDDIR  = obj_dir
LOG       = sim.log
PASSMSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) -Mdir $(BUILDDIR)

run: build
	./$(BUILDDIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qF '$(PASSMSG)' $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- testbench/tbKeyExpand.sv
`include "aesKey_macros.svh"

module tbKeyExpand;

  localparam int numExpansions = 5;
  localparam int timeoutCycles = numExpansions * 12 + 200;
  localparam aesKeyPkg::roundKeyT fipsKey = 128'h2b7e151628aed2a6abf7158809cf4f3c;

  logic                CLK;
  logic                CLR;
  logic                start;
  aesKeyPkg::roundKeyT cipherKey;
  aesKeyPkg::roundIdxT rdRound;
  aesKeyPkg::roundKeyT roundKey;
  logic                done;
  logic [31:0]         lfsr;
  int                  cycleCnt = 0;

  tbClock clockGen (
    .CLK(CLK),
    .CLR(CLR)
  );

  keyExpand i_dut (
    .CLK      (CLK),
    .CLR      (CLR),
    .start    (start),
    .cipherKey(cipherKey),
    .rdRound  (rdRound),
    .roundKey (roundKey),
    .done     (done)
  );

  bind keyExpand keyExpandAssert assertChk (
    .CLK      (CLK),
    .CLR      (CLR),
    .start    (start),
    .cipherKey(cipherKey),
    .rdRound  (rdRound),
    .roundKey (roundKey),
    .done     (done)
  );

  // ##################################################
  // Random bits.
  // ##################################################
  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output aesKeyPkg::roundKeyT val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[126:0], lfsr[0]};
      lfsr = galoisStep(lfsr); // One step per bit.
    end
  endtask

  // ##################################################
  // Stimulus tasks.
  // ##################################################
  task automatic runExpansion(input aesKeyPkg::roundKeyT key, input logic poke);
    aesKeyPkg::roundKeyT junk;
    @(posedge CLK);
    start     <= 1'b1;
    cipherKey <= key;
    @(posedge CLK); // Accepted on this edge.
    start <= 1'b0;
    if (poke) begin
      takeBits(128, junk);
      repeat (3) @(posedge CLK);
      start     <= 1'b1; // Lands while busy.
      cipherKey <= junk;
      @(posedge CLK);
      start <= 1'b0;
    end
    @(negedge CLK);
    while (!done) begin
      @(negedge CLK);
    end
  endtask

  // Round r, then round r-1.
  task automatic sweepChain();
    for (int r = 1; r <= `aesNumRounds; r++) begin
      @(posedge CLK);
      rdRound <= aesKeyPkg::roundIdxT'(r);
      @(posedge CLK);
      rdRound <= aesKeyPkg::roundIdxT'(r - 1);
    end
    @(posedge CLK);
  endtask

  task automatic randomReads(input int n);
    aesKeyPkg::roundKeyT bits;
    for (int i = 0; i < n; i++) begin
      takeBits(4, bits);
      @(posedge CLK);
      rdRound <= bits[3:0];
    end
    @(posedge CLK);
  endtask

  always @(posedge CLK) begin
    cycleCnt++;
    if (cycleCnt >= timeoutCycles) begin
      $display("Timeout: no verdict after %0d cycles", cycleCnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    aesKeyPkg::roundKeyT key;
    int errs;
    start     = 1'b0;
    cipherKey = '0;
    rdRound   = '0;
    lfsr      = 32'd71570;
    @(negedge CLR);
    runExpansion(fipsKey, 1'b1);
    sweepChain();
    randomReads(6);
    for (int n = 1; n < numExpansions; n++) begin
      takeBits(128, key);
      runExpansion(key, (n % 2) == 1);
      sweepChain();
      randomReads(6);
    end
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    errs = i_dut.assertChk.errCount;
    $display("Closing: %0d errors", errs);
    if (errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- testbench/keyExpand_assert.sv
`include "aesKey_macros.svh"

module keyExpandAssert (
  input logic                CLK,
  input logic                CLR,
  input logic                start,
  input aesKeyPkg::roundKeyT cipherKey,
  input aesKeyPkg::roundIdxT rdRound,
  input aesKeyPkg::roundKeyT roundKey,
  input logic                done
);

  // FIPS-197 appendix A.1 vectors.
  localparam aesKeyPkg::roundKeyT fipsKey     = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam aesKeyPkg::roundKeyT fipsRound1  = 128'ha0fafe1788542cb123a339392a6c7605;
  localparam aesKeyPkg::roundKeyT fipsRound10 = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;

  int                  errCount = 0;
  int                  cyclesLeft;
  logic                accepted;
  logic                doneModel;
  logic                fipsRun;
  aesKeyPkg::roundKeyT firstKey;
  aesKeyPkg::roundKeyT prevKey;
  aesKeyPkg::roundIdxT prevRound;
  logic                prevDone;
  logic [95:0]         chainExp;

  assign accepted = start && (cyclesLeft == 0);

  // ##################################################
  // Expected done timing and accepted key.
  // ##################################################
  always_ff @(posedge CLK or posedge CLR) begin
    if (CLR) begin
      cyclesLeft <= 0;
      doneModel  <= 1'b0;
      fipsRun    <= 1'b0;
      firstKey   <= '0;
    end else if (accepted) begin
      cyclesLeft <= `aesNumRounds;
      doneModel  <= 1'b0;
      fipsRun    <= (cipherKey == fipsKey);
      firstKey   <= cipherKey;
    end else if (cyclesLeft != 0) begin
      cyclesLeft <= cyclesLeft - 1;
      doneModel  <= (cyclesLeft == 1); // Tenth edge after start.
    end
  end

  // Previous read for the chaining check.
  always_ff @(posedge CLK) begin
    prevKey   <= roundKey;
    prevRound <= rdRound;
    prevDone  <= done;
  end

  // Words 1 to 3 of round r-1 from round r.
  assign chainExp = prevKey[95:0] ^ prevKey[127:32];

  // ##################################################
  // Checks.
  // ##################################################
  aResetDone: assert property (@(posedge CLK) (CLR || $fell(CLR)) |-> !done)
    else begin
      errCount++;
      $error("ERR resetDone expected 0 actual %b", $sampled(done));
    end

  aResetKey: assert property (@(posedge CLK) (CLR || $fell(CLR)) |-> roundKey == '0)
    else begin
      errCount++;
      $error("ERR resetKey expected 0 actual %h", $sampled(roundKey));
    end

  aLatency: assert property (@(posedge CLK) disable iff (CLR) done == doneModel)
    else begin
      errCount++;
      $error("ERR latency expected %b actual %b", $sampled(doneModel), $sampled(done));
    end

  aRound0: assert property (@(posedge CLK) disable iff (CLR)
      (done && rdRound == 4'd0) |-> roundKey == firstKey)
    else begin
      errCount++;
      $error("ERR round0 expected %h actual %h", $sampled(firstKey), $sampled(roundKey));
    end

  aFipsRound1: assert property (@(posedge CLK) disable iff (CLR)
      (done && fipsRun && rdRound == 4'd1) |-> roundKey == fipsRound1)
    else begin
      errCount++;
      $error("ERR fipsRound1 expected %h actual %h", fipsRound1, $sampled(roundKey));
    end

  aFipsRound10: assert property (@(posedge CLK) disable iff (CLR)
      (done && fipsRun && rdRound == 4'd10) |-> roundKey == fipsRound10)
    else begin
      errCount++;
      $error("ERR fipsRound10 expected %h actual %h", fipsRound10, $sampled(roundKey));
    end

  aChain: assert property (@(posedge CLK) disable iff (CLR)
      (done && prevDone && prevRound != 4'd0 && prevRound <= 4'd10
       && rdRound == prevRound - 4'd1) |-> roundKey[95:0] == chainExp)
    else begin
      errCount++;
      $error("ERR chain expected %h actual %h", $sampled(chainExp), $sampled(roundKey[95:0]));
    end

  aHighIndex: assert property (@(posedge CLK) rdRound > 4'd10 |-> roundKey == '0)
    else begin
      errCount++;
      $error("ERR highIndex expected 0 actual %h", $sampled(roundKey));
    end

endmodule

//--- testbench/tbClock.sv
module tbClock (
  output logic CLK,
  output logic CLR
);

  // Free-running clock, period 10.
  initial begin
    CLK = 1'b0;
    forever begin
      #5 CLK = ~CLK;
    end
  end

  // Reset held for three rising edges.
  initial begin
    CLR = 1'b1;
    repeat (3) @(posedge CLK);
    CLR <= 1'b0;
  end

endmodule

//--- logic/keyExpand.sv
module keyExpand (
  input  logic                CLK,
  input  logic                CLR,
  input  logic                start,
  input  aesKeyPkg::roundKeyT cipherKey,
  input  aesKeyPkg::roundIdxT rdRound,
  output aesKeyPkg::roundKeyT roundKey,
  output logic                done
);

  aesKeyPkg::roundKeyT curKey;
  aesKeyPkg::roundKeyT nextKey;
  aesKeyPkg::byteT     rcon;
  logic                wrEn;
  aesKeyPkg::roundIdxT wrRound;
  aesKeyPkg::roundKeyT wrKey;

  keySequencer sequencer (
    .CLK      (CLK),
    .CLR      (CLR),
    .start    (start),
    .cipherKey(cipherKey),
    .nextKey  (nextKey),
    .curKey   (curKey),
    .rcon     (rcon),
    .wrEn     (wrEn),
    .wrRound  (wrRound),
    .wrKey    (wrKey),
    .done     (done)
  );

  // One round of the schedule per clock.
  keyRoundStep roundStep (
    .curKey (curKey),
    .rcon   (rcon),
    .nextKey(nextKey)
  );

  roundKeyStore keyStore (
    .CLK    (CLK),
    .CLR    (CLR),
    .wrEn   (wrEn),
    .wrRound(wrRound),
    .wrKey  (wrKey),
    .rdRound(rdRound),
    .rdKey  (roundKey)
  );

endmodule

//--- logic/roundKeyStore.sv
`include "aesKey_macros.svh"

module roundKeyStore (
  input  logic                CLK,
  input  logic                CLR,
  input  logic                wrEn,
  input  aesKeyPkg::roundIdxT wrRound,
  input  aesKeyPkg::roundKeyT wrKey,
  input  aesKeyPkg::roundIdxT rdRound,
  output aesKeyPkg::roundKeyT rdKey
);

  // Initial key plus one entry per round.
  aesKeyPkg::roundKeyT keyBank [0:`aesNumRounds];

  always_ff @(posedge CLK or posedge CLR) begin
    if (CLR) begin
      for (int i = 0; i <= `aesNumRounds; i++) begin
        keyBank[i] <= '0;
      end
    end else if (wrEn && wrRound <= aesKeyPkg::roundIdxT'(`aesNumRounds)) begin
      keyBank[wrRound] <= wrKey;
    end
  end

  // Round-indexed read.
  always_comb begin
    if (rdRound <= aesKeyPkg::roundIdxT'(`aesNumRounds)) begin
      rdKey = keyBank[rdRound];
    end else begin
      rdKey = '0; // Out of range.
    end
  end

endmodule

//--- logic/keySequencer.sv
`include "aesKey_macros.svh"

module keySequencer (
  input  logic                CLK,
  input  logic                CLR,
  input  logic                start,
  input  aesKeyPkg::roundKeyT cipherKey,
  input  aesKeyPkg::roundKeyT nextKey,
  output aesKeyPkg::roundKeyT curKey,
  output aesKeyPkg::byteT     rcon,
  output logic                wrEn,
  output aesKeyPkg::roundIdxT wrRound,
  output aesKeyPkg::roundKeyT wrKey,
  output logic                done
);

  logic                busy;
  logic                accept;
  logic                lastRound;
  aesKeyPkg::roundIdxT roundCnt;
  aesKeyPkg::roundIdxT roundNext;
  aesKeyPkg::byteT     rconReg;
  aesKeyPkg::byteT     rconNext;
  aesKeyPkg::roundKeyT curKeyReg;

  assign accept    = start & ~busy; // Start while busy is dropped.
  assign roundNext = aesKeyPkg::roundIdxT'(roundCnt + 4'd1);
  assign lastRound = (roundNext == aesKeyPkg::roundIdxT'(`aesNumRounds));
  assign rconNext  = {rconReg[6:0], 1'b0} ^ (rconReg[7] ? 8'h1b : 8'h00);

  // ##################################################
  // Write side of the key store.
  // ##################################################
  assign wrEn    = accept | busy;
  assign wrRound = busy ? roundNext : '0;
  assign wrKey   = busy ? nextKey : cipherKey;

  always_ff @(posedge CLK or posedge CLR) begin
    if (CLR) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      roundCnt <= '0;
      rconReg  <= '0;
    end else if (accept) begin
      busy     <= 1'b1;
      done     <= 1'b0;
      roundCnt <= '0;
      rconReg  <= `aesRconInit;
    end else if (busy) begin
      roundCnt <= roundNext;
      rconReg  <= rconNext;
      if (lastRound) begin
        busy <= 1'b0;
        done <= 1'b1; // Rises with the round-10 write.
      end
    end
  end

  // Current key, payload only.
  always_ff @(posedge CLK) begin
    if (accept) begin
      curKeyReg <= cipherKey;
    end else if (busy) begin
      curKeyReg <= nextKey;
    end
  end

  assign curKey = curKeyReg;
  assign rcon   = rconReg;

endmodule

//--- logic/keyRoundStep.sv
`include "aesKey_macros.svh"

module keyRoundStep (
  input  aesKeyPkg::roundKeyT curKey,
  input  aesKeyPkg::byteT     rcon,
  output aesKeyPkg::roundKeyT nextKey
);

  aesKeyPkg::keyWordT oldWord [0:`aesKeyWords-1];
  aesKeyPkg::keyWordT newWord [0:`aesKeyWords-1];
  aesKeyPkg::keyWordT rotWord;
  aesKeyPkg::keyWordT subWord;
  aesKeyPkg::keyWordT tWord;

  genvar g;
  for (g = 0; g < `aesKeyWords; g++) begin : gWords
    assign oldWord[g] = curKey[(`aesKeyWords-1-g)*`aesWordBits +: `aesWordBits];
    assign nextKey[(`aesKeyWords-1-g)*`aesWordBits +: `aesWordBits] = newWord[g];
  end

  assign rotWord = {oldWord[`aesKeyWords-1][23:0], oldWord[`aesKeyWords-1][31:24]}; // RotWord.

  // SubWord, one S-box per byte.
  for (g = 0; g < `aesWordBits / 8; g++) begin : gSub
    aesSbox sbox (
      .inByte (rotWord[8*g +: 8]),
      .outByte(subWord[8*g +: 8])
    );
  end

  assign tWord = subWord ^ {rcon, 24'h000000};

  always_comb begin
    newWord[0] = oldWord[0] ^ tWord;
    for (int i = 1; i < `aesKeyWords; i++) begin
      newWord[i] = oldWord[i] ^ newWord[i-1]; // Chained XOR.
    end
  end

endmodule

//--- logic/aesSbox.sv
module aesSbox (
  input  aesKeyPkg::byteT inByte,
  output aesKeyPkg::byteT outByte
);

  // GF(2^8) multiply, reduction polynomial x^8+x^4+x^3+x+1.
  function automatic aesKeyPkg::byteT gfMul(input aesKeyPkg::byteT a,
                                            input aesKeyPkg::byteT b);
    aesKeyPkg::byteT acc;
    aesKeyPkg::byteT sh;
    acc = 8'h00;
    sh = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

  aesKeyPkg::byteT x2;
  aesKeyPkg::byteT x3;
  aesKeyPkg::byteT x6;
  aesKeyPkg::byteT x12;
  aesKeyPkg::byteT x15;
  aesKeyPkg::byteT x30;
  aesKeyPkg::byteT x60;
  aesKeyPkg::byteT x120;
  aesKeyPkg::byteT x240;
  aesKeyPkg::byteT x252;
  aesKeyPkg::byteT inv;

  // ##################################################
  // Inverse as x^254; zero stays zero.
  // ##################################################
  assign x2   = gfMul(inByte, inByte);
  assign x3   = gfMul(x2, inByte);
  assign x6   = gfMul(x3, x3);
  assign x12  = gfMul(x6, x6);
  assign x15  = gfMul(x12, x3);
  assign x30  = gfMul(x15, x15);
  assign x60  = gfMul(x30, x30);
  assign x120 = gfMul(x60, x60);
  assign x240 = gfMul(x120, x120);
  assign x252 = gfMul(x240, x12);
  assign inv  = gfMul(x252, x2);

  // ##################################################
  // Affine transform.
  // ##################################################
  assign outByte = inv
                 ^ {inv[6:0], inv[7]}
                 ^ {inv[5:0], inv[7:6]}
                 ^ {inv[4:0], inv[7:5]}
                 ^ {inv[3:0], inv[7:4]}
                 ^ 8'h63;

endmodule

//--- logic/aesKeyPkg.sv
`include "aesKey_macros.svh"

package aesKeyPkg;

  // One schedule word.
  typedef logic [`aesWordBits-1:0] keyWordT;

  // Word 0 sits in the top 32 bits.
  typedef logic [`aesKeyWords*`aesWordBits-1:0] roundKeyT;

  // Round index, 0 to 10.
  typedef logic [3:0] roundIdxT;

  // S-box and Rcon bytes.
  typedef logic [7:0] byteT;

endpackage

//--- logic/aesKey_macros.svh
`ifndef AES_KEY_MACROS_SVH
`define AES_KEY_MACROS_SVH

// ##################################################
// AES-128 key schedule dimensions.
// ##################################################

// Rounds after the initial key.
`define aesNumRounds 10

// Bits in one schedule word.
`define aesWordBits 32

// Words per round key (Nk for AES-128).
`define aesKeyWords 4

// First round constant.
`define aesRconInit 8'h01

`endif
